// File: all.f
+incdir+sim
design/sys_pkg.sv
design/sys_decode.sv
design/trap_ctrl.sv
design/csr_regs.sv
design/sys_unit.sv
sim/sys_unit_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = sys_unit_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/sys_tb_ref.svh
`ifndef SYS_TB_REF_SVH
`define SYS_TB_REF_SVH
`default_nettype none

// shadow copies of the four machine CSRs
typedef struct packed {
    sys_pkg::xword_t mstatus;
    sys_pkg::xword_t mtvec;
    sys_pkg::xword_t mepc;
    sys_pkg::xword_t mcause;
} shadow_t;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// csr instruction with rd = x1, src is the rs1 field or zimm
function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] addr,
                                        input logic [4:0] src);
    return {addr, src, f3, 5'd1, 7'h73};
endfunction

// expected outputs of one cycle, then the state after its clock edge
function automatic void ref_step(inout shadow_t sh, input logic valid,
                                 input logic [31:0] ins, input sys_pkg::xword_t pc,
                                 input sys_pkg::xword_t rs1,
                                 output sys_pkg::xword_t exp_rdata,
                                 output sys_pkg::redirect_t exp_redir);
    logic [2:0]      f3;
    logic [11:0]     addr;
    sys_pkg::xword_t opnd;
    sys_pkg::xword_t old;
    sys_pkg::xword_t nv;
    logic            known;
    logic            is_csr;
    logic            take;
    sys_pkg::xword_t cause;
    f3        = ins[14:12];
    addr      = ins[31:20];
    opnd      = f3[2] ? {59'd0, ins[19:15]} : rs1;
    old       = '0;
    known     = 1'b1;
    take      = 1'b0;
    cause     = 64'd2;
    exp_rdata = '0;
    exp_redir = '0;
    is_csr    = (f3 != 3'd0) && (f3 != 3'd4);
    case (addr)
        12'h300: old = sh.mstatus;
        12'h305: old = sh.mtvec;
        12'h341: old = sh.mepc;
        12'h342: old = sh.mcause;
        default: known = 1'b0;
    endcase
    case (f3[1:0])
        2'd1:    nv = opnd;
        2'd2:    nv = old | opnd;
        default: nv = old & ~opnd;
    endcase
    if (valid && ins[6:0] == 7'h73) begin
        if (f3 == 3'd0 && addr == 12'h000) begin
            take  = 1'b1;
            cause = 64'd11;
        end else if (f3 == 3'd0 && addr == 12'h302) begin
            exp_redir.valid = 1'b1;
            exp_redir.pc    = sh.mepc;
            sh.mstatus[3]   = sh.mstatus[7];
            sh.mstatus[7]   = 1'b1;
        end else if (is_csr && !known) begin
            take = 1'b1;
        end else if (is_csr) begin
            exp_rdata = old;
            case (addr)
                12'h300: sh.mstatus = nv;
                12'h305: sh.mtvec   = {nv[63:2], 2'b00};
                12'h341: sh.mepc    = {nv[63:2], 2'b00};
                default: sh.mcause  = nv;
            endcase
        end
    end
    if (take) begin
        exp_redir.valid   = 1'b1;
        exp_redir.pc      = sh.mtvec;
        sh.mepc           = {pc[63:2], 2'b00};
        sh.mcause         = cause;
        sh.mstatus[7]     = sh.mstatus[3];
        sh.mstatus[3]     = 1'b0;
        sh.mstatus[12:11] = 2'b11;
    end
endfunction

`default_nettype wire
`endif

// File: sim/sys_unit_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "sys_tb_ref.svh"
`default_nettype none

module sys_unit_tb;

    logic               clk;
    logic               rst_n;
    logic               instr_valid_i;
    logic [31:0]        instr_i;
    sys_pkg::xword_t    pc_i;
    sys_pkg::xword_t    rs1_data_i;
    sys_pkg::xword_t    csr_rdata_o;
    sys_pkg::redirect_t redirect_o;
    logic               mstatus_mie_o;

    logic [31:0] rng_state;
    int          n_valid;
    int          n_checked;
    shadow_t     shadow;

    sys_unit DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .csr_rdata_o   (csr_rdata_o),
        .redirect_o    (redirect_o),
        .mstatus_mie_o (mstatus_mie_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_xword(input string name, input sys_pkg::xword_t got,
                               input sys_pkg::xword_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error %s got %h exp %h", name, got, exp));
        end
    endtask

    // pc only matters while the redirect is valid
    task automatic check_redirect(input sys_pkg::redirect_t got,
                                  input sys_pkg::redirect_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
            stop_with_failure($sformatf("Error redirect_o got %h/%h exp %h/%h",
                                        got.valid, got.pc, exp.valid, exp.pc));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error %s got %h exp %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic sys_pkg::xword_t rand64();
        logic [31:0] hi;
        hi = rand32();
        return {hi, rand32()};
    endfunction

    function automatic logic [11:0] pick_addr(input logic [1:0] k);
        case (k)
            2'd0:    return 12'h300;
            2'd1:    return 12'h305;
            2'd2:    return 12'h341;
            default: return 12'h342;
        endcase
    endfunction

    // one instruction per cycle, random pc
    task automatic drive(input logic v, input logic [31:0] ins, input sys_pkg::xword_t rs1);
        @(posedge clk);
        instr_valid_i <= v;
        instr_i       <= ins;
        pc_i          <= rand64();
        rs1_data_i    <= rs1;
        if (v) begin
            n_valid++;
        end
    endtask

    // csrrsi with zimm 0 leaves the csr as it is
    task automatic read_csr(input logic [11:0] addr);
        drive(1'b1, enc_csr(3'd6, addr, 5'd0), rand64());
    endtask

    initial begin : compare
        sys_pkg::xword_t    exp_rdata;
        sys_pkg::redirect_t exp_redir;
        shadow         = '0;
        shadow.mstatus = 64'h0000000a00001800;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                check_bit("mstatus_mie_o", mstatus_mie_o, shadow.mstatus[3]);
                ref_step(shadow, instr_valid_i, instr_i, pc_i, rs1_data_i,
                         exp_rdata, exp_redir);
                check_xword("csr_rdata_o", csr_rdata_o, exp_rdata);
                check_redirect(redirect_o, exp_redir);
                if (instr_valid_i) begin
                    n_checked++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] bad;
        int          cnt;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        pc_i          <= '0;
        rs1_data_i    <= '0;
        rng_state     = 32'hebf6;
        n_valid       = 0;
        n_checked     = 0;
        cnt           = 0;
        while (rst_n !== 1'b1 && cnt < 10) begin
            @(posedge clk);
            cnt++;
        end
        if (rst_n !== 1'b1) begin
            stop_with_failure("reset was never released");
        end
        for (int k = 0; k < 4; k++) begin
            read_csr(pick_addr(k[1:0]));
        end
        // back to back csr ops, register and immediate forms
        repeat (200) begin
            r  = rand32() % 32'd6;
            f3 = (r < 32'd3) ? r[2:0] + 3'd1 : r[2:0] + 3'd2;
            r  = rand32();
            drive(1'b1, enc_csr(f3, pick_addr(r[1:0]), r[6:2]), rand64());
        end
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, enc_csr(3'd1, 12'h300, 5'd0), rand64());
            drive(1'b1, enc_csr(3'd6, 12'h300, 5'd8), '0);
            drive(1'b1, enc_csr(3'd1, 12'h305, 5'd0), rand64());
            drive(1'b1, 32'h00000073, rand64());
            read_csr(12'h341);
            read_csr(12'h342);
            read_csr(12'h300);
            // alternate MPIE so mret restores both levels
            drive(1'b1, enc_csr(i[0] ? 3'd3 : 3'd2, 12'h300, 5'd2), 64'h80);
            drive(1'b1, 32'h30200073, rand64());
            read_csr(12'h300);
        end
        // unimplemented csr addresses trap as illegal
        repeat (8) begin
            r   = rand32();
            bad = r[11:0];
            if (bad == 12'h300 || bad == 12'h305 || bad == 12'h341 || bad == 12'h342) begin
                bad = 12'h7c0;
            end
            drive(1'b1, enc_csr(r[12] ? 3'd1 : 3'd7, bad, r[17:13]), rand64());
            read_csr(12'h342);
            read_csr(12'h341);
        end
        repeat (20) begin
            r = rand32();
            drive(1'b0, r[0] ? 32'h00000073 : enc_csr(3'd1, 12'h300, r[5:1]), rand64());
            drive(1'b1, {r[31:7], 7'h33}, rand64());
        end
        for (int k = 0; k < 4; k++) begin
            read_csr(pick_addr(k[1:0]));
        end
        drive(1'b0, 32'h0, '0);
        cnt = 0;
        while (n_checked != n_valid && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (n_checked != n_valid) begin
            stop_with_failure("not every instruction was checked before the timeout");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/sys_unit.sv
`default_nettype none
`timescale 1ns/10ps

module sys_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid_i,
    input  logic [31:0]        instr_i,
    input  sys_pkg::xword_t    pc_i,
    input  sys_pkg::xword_t    rs1_data_i,
    output sys_pkg::xword_t    csr_rdata_o,
    output sys_pkg::redirect_t redirect_o,
    output logic               mstatus_mie_o
);

    sys_pkg::sys_op_t   op;
    sys_pkg::trap_evt_t evt;
    sys_pkg::xword_t    mtvec;
    sys_pkg::xword_t    mepc;

    sys_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .op_o          (op)
    );

    trap_ctrl u_trap (
        .op_i       (op),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .evt_o      (evt),
        .redirect_o (redirect_o)
    );

    csr_regs u_csr (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_i    (pc_i),
        .op_i    (op),
        .evt_i   (evt),
        .rdata_o (csr_rdata_o),
        .mtvec_o (mtvec),
        .mepc_o  (mepc),
        .mie_o   (mstatus_mie_o)
    );

endmodule

`default_nettype wire

// File: design/csr_regs.sv
`default_nettype none
`timescale 1ns/10ps

module csr_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  sys_pkg::xword_t    pc_i,
    input  sys_pkg::sys_op_t   op_i,
    input  sys_pkg::trap_evt_t evt_i,
    output sys_pkg::xword_t    rdata_o,
    output sys_pkg::xword_t    mtvec_o,
    output sys_pkg::xword_t    mepc_o,
    output logic               mie_o
);

    sys_pkg::xword_t mstatus;
    sys_pkg::xword_t mtvec;
    sys_pkg::xword_t mepc;
    sys_pkg::xword_t mcause;

    sys_pkg::xword_t old_val;
    sys_pkg::xword_t wdata;

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;

    // old value, zero when no csr is addressed
    always_comb begin
        case (op_i.csr_sel)
            sys_pkg::SEL_MSTATUS: old_val = mstatus;
            sys_pkg::SEL_MTVEC:   old_val = mtvec;
            sys_pkg::SEL_MEPC:    old_val = mepc;
            sys_pkg::SEL_MCAUSE:  old_val = mcause;
            default:              old_val = '0;
        endcase
    end

    // read-modify-write result
    always_comb begin
        case (op_i.csr_fn)
            sys_pkg::CSR_RW: wdata = op_i.operand;
            sys_pkg::CSR_RS: wdata = old_val | op_i.operand;
            sys_pkg::CSR_RC: wdata = old_val & ~op_i.operand;
            default:         wdata = op_i.operand;
        endcase
    end

    assign wr_mstatus = op_i.csr_en && (op_i.csr_sel == sys_pkg::SEL_MSTATUS);
    assign wr_mtvec   = op_i.csr_en && (op_i.csr_sel == sys_pkg::SEL_MTVEC);
    assign wr_mepc    = op_i.csr_en && (op_i.csr_sel == sys_pkg::SEL_MEPC);
    assign wr_mcause  = op_i.csr_en && (op_i.csr_sel == sys_pkg::SEL_MCAUSE);

    // trap entry and mret both touch only the interrupt stack bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= sys_pkg::MSTATUS_RESET;
        end else if (evt_i.take) begin
            mstatus[sys_pkg::MPIE_BIT]                   <= mstatus[sys_pkg::MIE_BIT];
            mstatus[sys_pkg::MIE_BIT]                    <= 1'b0;
            mstatus[sys_pkg::MPP_HI:sys_pkg::MPP_LO]     <= 2'b11;
        end else if (evt_i.ret) begin
            mstatus[sys_pkg::MIE_BIT]  <= mstatus[sys_pkg::MPIE_BIT];
            mstatus[sys_pkg::MPIE_BIT] <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus <= wdata;
        end
    end

    // direct mode only, low bits stay zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (wr_mtvec) begin
            mtvec <= {wdata[sys_pkg::XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (evt_i.take) begin
            mepc <= {pc_i[sys_pkg::XLEN-1:2], 2'b00};
        end else if (wr_mepc) begin
            mepc <= {wdata[sys_pkg::XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (evt_i.take) begin
            mcause <= evt_i.cause;
        end else if (wr_mcause) begin
            mcause <= wdata;
        end
    end

    assign rdata_o = old_val;
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;
    assign mie_o   = mstatus[sys_pkg::MIE_BIT];

endmodule

`default_nettype wire

// File: design/trap_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module trap_ctrl (
    input  sys_pkg::sys_op_t   op_i,
    input  sys_pkg::xword_t    mtvec_i,
    input  sys_pkg::xword_t    mepc_i,
    output sys_pkg::trap_evt_t evt_o,
    output sys_pkg::redirect_t redirect_o
);

    logic take;
    logic ret;

    // decoder already qualifies every flag with valid
    assign take = op_i.ecall || op_i.illegal;
    assign ret  = op_i.mret;

    always_comb begin
        evt_o      = '0;
        evt_o.take = take;
        evt_o.ret  = ret;
        if (op_i.ecall) begin
            evt_o.cause = sys_pkg::CAUSE_ECALL_M;
        end else if (op_i.illegal) begin
            evt_o.cause = sys_pkg::CAUSE_ILLEGAL;
        end
    end

    // trap goes to the handler, mret back to the saved pc
    always_comb begin
        redirect_o       = '0;
        redirect_o.valid = take || ret;
        if (take) begin
            redirect_o.pc = mtvec_i;
        end else if (ret) begin
            redirect_o.pc = mepc_i;
        end
    end

endmodule

`default_nettype wire

// File: design/sys_decode.sv
`default_nettype none
`timescale 1ns/10ps

module sys_decode (
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    input  sys_pkg::xword_t  rs1_data_i,
    output sys_pkg::sys_op_t op_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [11:0]       imm12;
    sys_pkg::xword_t   zimm;
    logic              is_system;
    logic              is_csr;
    sys_pkg::csr_sel_t sel;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign imm12  = instr_i[31:20];
    // rs1 field doubles as the 5-bit immediate
    assign zimm   = {{(sys_pkg::XLEN - 5){1'b0}}, instr_i[19:15]};

    assign is_system = instr_valid_i && (opcode == sys_pkg::OPC_SYSTEM);

    // map the csr address onto the implemented set
    always_comb begin
        case (imm12)
            sys_pkg::ADDR_MSTATUS: sel = sys_pkg::SEL_MSTATUS;
            sys_pkg::ADDR_MTVEC:   sel = sys_pkg::SEL_MTVEC;
            sys_pkg::ADDR_MEPC:    sel = sys_pkg::SEL_MEPC;
            sys_pkg::ADDR_MCAUSE:  sel = sys_pkg::SEL_MCAUSE;
            default:               sel = sys_pkg::SEL_NONE;
        endcase
    end

    always_comb begin
        op_o   = '0;
        is_csr = 1'b0;
        if (is_system) begin
            case (funct3)
                sys_pkg::F3_PRIV: begin
                    op_o.ecall = (imm12 == sys_pkg::IMM12_ECALL);
                    op_o.mret  = (imm12 == sys_pkg::IMM12_MRET);
                end
                sys_pkg::F3_CSRRW, sys_pkg::F3_CSRRWI: begin
                    is_csr      = 1'b1;
                    op_o.csr_fn = sys_pkg::CSR_RW;
                end
                sys_pkg::F3_CSRRS, sys_pkg::F3_CSRRSI: begin
                    is_csr      = 1'b1;
                    op_o.csr_fn = sys_pkg::CSR_RS;
                end
                sys_pkg::F3_CSRRC, sys_pkg::F3_CSRRCI: begin
                    is_csr      = 1'b1;
                    op_o.csr_fn = sys_pkg::CSR_RC;
                end
                default: is_csr = 1'b0;
            endcase
        end
        // unknown address becomes a trap, never a write
        if (is_csr) begin
            op_o.csr_sel = sel;
            op_o.csr_en  = (sel != sys_pkg::SEL_NONE);
            op_o.illegal = (sel == sys_pkg::SEL_NONE);
            op_o.operand = funct3[2] ? zimm : rs1_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/sys_pkg.sv
`default_nettype none

package sys_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xword_t;

    // machine CSR addresses
    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;

    // SYSTEM opcode and funct3 encodings
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [2:0] F3_PRIV    = 3'd0;
    localparam logic [2:0] F3_CSRRW   = 3'd1;
    localparam logic [2:0] F3_CSRRS   = 3'd2;
    localparam logic [2:0] F3_CSRRC   = 3'd3;
    localparam logic [2:0] F3_CSRRWI  = 3'd5;
    localparam logic [2:0] F3_CSRRSI  = 3'd6;
    localparam logic [2:0] F3_CSRRCI  = 3'd7;

    localparam logic [11:0] IMM12_ECALL = 12'h000;
    localparam logic [11:0] IMM12_MRET  = 12'h302;

    localparam xword_t CAUSE_ECALL_M = 64'd11;
    localparam xword_t CAUSE_ILLEGAL = 64'd2;

    // MPP reads as machine after reset, UXL/SXL fixed at 64 bit
    localparam xword_t MSTATUS_RESET = 64'h0000000a00001800;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;
    localparam int MPP_HI   = 12;

    typedef enum logic [1:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC
    } csr_fn_t;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_MSTATUS,
        SEL_MTVEC,
        SEL_MEPC,
        SEL_MCAUSE
    } csr_sel_t;

    typedef struct packed {
        logic     csr_en;
        csr_fn_t  csr_fn;
        csr_sel_t csr_sel;
        xword_t   operand;
        logic     illegal;
        logic     ecall;
        logic     mret;
    } sys_op_t;

    typedef struct packed {
        logic   take;
        logic   ret;
        xword_t cause;
    } trap_evt_t;

    typedef struct packed {
        logic   valid;
        xword_t pc;
    } redirect_t;

endpackage

`default_nettype wire
